//--- Makefile
TOP = tb_fei4_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
verilog/rx_link_pkg.sv
verilog/rx_bus_pkg.sv
verilog/rx_symbol_align.sv
verilog/rx_8b10b_decode.sv
verilog/rx_frame_assembler.sv
verilog/rx_word_fifo.sv
verilog/rx_core_regs.sv
verilog/fei4_rx_top.sv
tb/tb_fei4_rx.sv

//--- tb/tb_fei4_rx.sv
`timescale 1ns/1ps

module tb_fei4_rx
    import rx_link_pkg::*;
    import rx_bus_pkg::*;
;

    typedef struct packed {
        logic [3:0] n_frames;
        logic [1:0] n_rec;      // records per frame
        logic       bad;        // broken frame first
        logic       inv;        // line polarity
        logic       relink;     // link reset and new control value first
        logic       pop;
        logic [7:0] exp_dec;
        logic [7:0] exp_lost;
    } test_t;

    localparam int NTESTS = 5;
    localparam sym10_t BAD_SYM = 10'b1101110101;   // 6b part not a valid code

    logic       BUS_CLK = 1'b0;
    logic       RST = 1'b1;
    logic       rx_data = 1'b0;
    logic       fifo_read = 1'b0;
    bus_req_t   bus = '0;
    fifo_word_t fifo_data;
    logic       fifo_empty, fifo_full, rx_ready, dec_err_flag, lost_err_flag;
    logic [7:0] bus_data_out;

    // payload bytes whose codes have short runs, so no false comma appears
    logic [7:0] payload [8] = '{8'hB5, 8'h4A, 8'hAA, 8'h55, 8'h45, 8'hA9, 8'h52, 8'hBA};
    string      names [NTESTS] = '{"sync_inverted", "three_frames", "bad_symbol",
                                   "overflow", "relink_plain"};
    test_t      tests [NTESTS] = '{
        '{n_frames: 0, n_rec: 0, bad: 0, inv: 1, relink: 0, pop: 1, exp_dec: 0, exp_lost: 0},
        '{n_frames: 3, n_rec: 2, bad: 0, inv: 1, relink: 0, pop: 1, exp_dec: 0, exp_lost: 0},
        '{n_frames: 1, n_rec: 2, bad: 1, inv: 1, relink: 0, pop: 1, exp_dec: 1, exp_lost: 0},
        '{n_frames: 7, n_rec: 3, bad: 0, inv: 1, relink: 0, pop: 0, exp_dec: 1, exp_lost: 5},
        '{n_frames: 1, n_rec: 2, bad: 0, inv: 0, relink: 1, pop: 1, exp_dec: 0, exp_lost: 0}
    };

    sym10_t     sym_q[$];
    fifo_word_t exp_q[$];
    sym10_t     cur_sym;
    logic       cur_inv, tb_inv = 1'b1;
    logic       from_q = 1'b0;
    int         bit_idx = 0;
    int         seed = 54257;
    int         errors = 0;
    int         passed = 0;
    int         cycles = 0;
    int         limit = 0;

    fei4_rx_top #(.data_id(8'hA5)) i_dut (
        .BUS_CLK(BUS_CLK), .RST(RST), .rx_data(rx_data), .fifo_read(fifo_read), .bus(bus),
        .fifo_data(fifo_data), .fifo_empty(fifo_empty), .fifo_full(fifo_full),
        .rx_ready(rx_ready), .dec_err_flag(dec_err_flag), .lost_err_flag(lost_err_flag),
        .bus_data_out(bus_data_out)
    );

    always #4 BUS_CLK = ~BUS_CLK;

    function automatic sym10_t encode(input logic k, input logic [7:0] b);
        case ({k, b})
            9'h1BC:  return 10'b0011111010;  // K28.5
            9'h1FC:  return 10'b0011111000;  // K28.7
            9'h17C:  return 10'b0011110011;  // K28.3
            9'h0B5:  return 10'b1010101010;
            9'h04A:  return 10'b0101010101;
            9'h0AA:  return 10'b0101011010;
            9'h055:  return 10'b1010100101;
            9'h045:  return 10'b1010010101;
            9'h0A9:  return 10'b1001011010;
            9'h052:  return 10'b0100110101;
            9'h0BA:  return 10'b0101101010;
            default: return BAD_SYM;
        endcase
    endfunction

    // line driver, MSB first, commas whenever nothing is queued
    always @(negedge BUS_CLK) begin
        if (bit_idx == 0) begin
            from_q  = (sym_q.size() != 0);
            cur_sym = from_q ? sym_q.pop_front() : encode(1'b1, K28_5);
            cur_inv = tb_inv;   // polarity only changes at a symbol boundary
        end
        rx_data <= cur_sym[9 - bit_idx] ^ cur_inv;
        bit_idx = (bit_idx == 9) ? 0 : bit_idx + 1;
    end

    always @(posedge BUS_CLK) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, DUT stopped responding", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_word(input string name, input fifo_word_t exp, input fifo_word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] val);
        @(negedge BUS_CLK);
        bus.add     = addr;
        bus.data_in = val;
        bus.wr      = 1'b1;
        @(negedge BUS_CLK);
        bus.wr      = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [7:0] val);
        @(negedge BUS_CLK);
        bus.add = addr;
        @(negedge BUS_CLK);     // readback registered one edge later
        val = bus_data_out;
    endtask

    task automatic queue_frame(input int n_rec);
        fe_record_t rec;
        fifo_word_t word;
        logic [7:0] b;
        sym_q.push_back(encode(1'b1, K28_7));
        for (int r = 0; r < n_rec; r++) begin
            for (int i = 0; i < 3; i++) begin
                b = payload[$unsigned($random(seed)) % 8];
                sym_q.push_back(encode(1'b0, b));
                rec[2 - i] = b;     // first byte on top
            end
            word.header = 8'hA5;
            word.rec    = rec;
            if (exp_q.size() < FIFO_DEPTH)
                exp_q.push_back(word);
        end
        sym_q.push_back(encode(1'b1, K28_3));
    endtask

    initial begin
        logic [7:0] rd;
        int         err0;
        int         nsym;
        test_t      t;

        nsym = 0;
        foreach (tests[i])
            nsym += 6 + (tests[i].bad ? 6 : 0) + tests[i].n_frames * (2 + 3 * tests[i].n_rec);
        limit = nsym * 10 + 2000;

        repeat (5) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        RST = 1'b0;

        // reset state, read before the idle commas can align
        bus_read(ADDR_RESET, rd);
        check_byte("reset_version", 8'h02, rd);
        bus_read(ADDR_CTRL, rd);
        check_byte("reset_ctrl", 8'h02, rd);
        check_bit("reset_empty", 1'b1, fifo_empty);
        check_bit("reset_dec_flag", 1'b0, dec_err_flag);
        check_bit("reset_lost_flag", 1'b0, lost_err_flag);
        $display("test reset_state: %s", errors == 0 ? "ok" : "errors");
        if (errors == 0)
            passed++;

        for (int n = 0; n < NTESTS; n++) begin
            t    = tests[n];
            err0 = errors;
            if (t.relink) begin
                bus_write(ADDR_RX_RESET, 8'h00);
                exp_q.delete();
                bus_read(ADDR_DEC_ERR, rd);
                check_byte({names[n], "_dec_cleared"}, 8'h00, rd);
                bus_read(ADDR_LOST_ERR, rd);
                check_byte({names[n], "_lost_cleared"}, 8'h00, rd);
                check_bit({names[n], "_ready_cleared"}, 1'b0, rx_ready);
                bus_write(ADDR_CTRL, t.inv ? 8'h02 : 8'h00);
                tb_inv = t.inv;
            end
            repeat (6) sym_q.push_back(encode(1'b1, K28_5));
            if (t.bad) begin
                // bytes after the bad symbol would complete a record if it were kept
                sym_q.push_back(encode(1'b1, K28_7));
                sym_q.push_back(encode(1'b0, payload[0]));
                sym_q.push_back(BAD_SYM);
                sym_q.push_back(encode(1'b0, payload[1]));
                sym_q.push_back(encode(1'b0, payload[2]));
                sym_q.push_back(encode(1'b1, K28_3));
            end
            for (int f = 0; f < t.n_frames; f++)
                queue_frame(t.n_rec);
            while (sym_q.size() != 0 || from_q)
                @(posedge BUS_CLK);
            repeat (12) @(negedge BUS_CLK);     // pipeline to the FIFO

            check_bit({names[n], "_ready"}, 1'b1, rx_ready);
            bus_read(ADDR_CTRL, rd);
            check_byte({names[n], "_ctrl"}, (t.inv ? 8'h02 : 8'h00) | 8'h01, rd);
            bus_read(ADDR_SIZE_LO, rd);
            check_byte({names[n], "_size_lo"}, 8'(exp_q.size()), rd);
            bus_read(ADDR_SIZE_HI, rd);
            check_byte({names[n], "_size_hi"}, 8'h00, rd);
            bus_read(ADDR_DEC_ERR, rd);
            check_byte({names[n], "_dec_cnt"}, t.exp_dec, rd);
            bus_read(ADDR_LOST_ERR, rd);
            check_byte({names[n], "_lost_cnt"}, t.exp_lost, rd);
            check_bit({names[n], "_dec_flag"}, t.exp_dec != 0, dec_err_flag);
            check_bit({names[n], "_lost_flag"}, t.exp_lost != 0, lost_err_flag);
            check_bit({names[n], "_full"}, exp_q.size() == FIFO_DEPTH, fifo_full);

            if (t.pop) begin
                while (exp_q.size() != 0) begin
                    @(negedge BUS_CLK);
                    fifo_read = 1'b0;
                    check_bit({names[n], "_not_empty"}, 1'b0, fifo_empty);
                    check_word({names[n], "_word"}, exp_q.pop_front(), fifo_data);
                    fifo_read = 1'b1;
                end
                @(negedge BUS_CLK);
                fifo_read = 1'b0;
                check_bit({names[n], "_drained"}, 1'b1, fifo_empty);
            end
            $display("test %s: %s", names[n], errors == err0 ? "ok" : "errors");
            if (errors == err0)
                passed++;
        end

        $display("tests ok %0d of %0d, check errors %0d", passed, NTESTS + 1, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- verilog/fei4_rx_top.sv
`timescale 1ns/1ps

module fei4_rx_top
    import rx_link_pkg::*;
    import rx_bus_pkg::*;
#(
    parameter logic [7:0] data_id = 8'h00
) (
    input  logic       BUS_CLK,
    input  logic       RST,
    input  logic       rx_data,
    input  logic       fifo_read,
    input  bus_req_t   bus,
    output fifo_word_t fifo_data,
    output logic       fifo_empty,
    output logic       fifo_full,
    output logic       rx_ready,
    output logic       dec_err_flag,
    output logic       lost_err_flag,
    output logic [7:0] bus_data_out
);

    logic        link_rst;
    logic        invert;
    sym10_t      sym;
    logic        sym_valid;
    dec_byte_t   dec_byte;
    logic        byte_valid;
    logic        code_err;
    fe_record_t  rec;
    logic        rec_valid;
    logic [15:0] fifo_size;
    logic [7:0]  lost_cnt;
    logic [7:0]  dec_err_cnt;

    rx_core_regs i_regs (
        .BUS_CLK(BUS_CLK), .RST(RST), .bus(bus), .ready(rx_ready),
        .size(fifo_size), .dec_err_cnt(dec_err_cnt), .lost_cnt(lost_cnt),
        .bus_data_out(bus_data_out), .link_rst(link_rst), .full_rst(), .invert(invert)
    );

    rx_symbol_align i_align (
        .BUS_CLK(BUS_CLK), .RST(RST), .link_rst(link_rst), .rx_data(rx_data),
        .invert(invert), .sym(sym), .sym_valid(sym_valid), .ready(rx_ready)
    );

    rx_8b10b_decode i_decode (
        .BUS_CLK(BUS_CLK), .RST(RST), .sym(sym), .sym_valid(sym_valid),
        .byte_out(dec_byte), .byte_valid(byte_valid), .code_err(code_err)
    );

    rx_frame_assembler i_frame (
        .BUS_CLK(BUS_CLK), .RST(RST), .link_rst(link_rst), .byte_in(dec_byte),
        .byte_valid(byte_valid), .code_err(code_err), .rec(rec), .rec_valid(rec_valid)
    );

    rx_word_fifo i_fifo (
        .BUS_CLK(BUS_CLK), .RST(RST), .link_rst(link_rst), .wr_rec(rec),
        .wr_en(rec_valid), .rd_en(fifo_read), .header(data_id), .data(fifo_data),
        .empty(fifo_empty), .full(fifo_full), .size(fifo_size), .lost_cnt(lost_cnt)
    );

    always_ff @(posedge BUS_CLK) begin
        if (RST || link_rst)
            dec_err_cnt <= 8'd0;
        else if (code_err && dec_err_cnt != 8'hFF)     // stops at 255
            dec_err_cnt <= dec_err_cnt + 8'd1;
    end

    assign dec_err_flag  = (dec_err_cnt != 8'd0);
    assign lost_err_flag = (lost_cnt != 8'd0);

endmodule

//--- verilog/rx_8b10b_decode.sv
`timescale 1ns/1ps

module rx_8b10b_decode
    import rx_link_pkg::*;
(
    input  logic      BUS_CLK,
    input  logic      RST,
    input  sym10_t    sym,
    input  logic      sym_valid,
    output dec_byte_t byte_out,
    output logic      byte_valid,
    output logic      code_err
);

    logic [4:0] dec_5b;
    logic [2:0] dec_3b;
    logic [3:0] fghj;
    logic       ok_6b;
    logic       ok_4b;
    logic       is_k;

    // 110000 is the complemented K28 form, flip fghj so one table serves
    assign fghj = (sym[9:4] == 6'b110000) ? ~sym[3:0] : sym[3:0];

    always_comb begin
        dec_5b = 5'd0;
        ok_6b  = 1'b1;
        is_k   = 1'b0;
        case (sym[9:4])                             // abcdei, RD- and RD+ forms
            6'b100111, 6'b011000: dec_5b = 5'd0;
            6'b011101, 6'b100010: dec_5b = 5'd1;
            6'b101101, 6'b010010: dec_5b = 5'd2;
            6'b110001:            dec_5b = 5'd3;
            6'b110101, 6'b001010: dec_5b = 5'd4;
            6'b101001:            dec_5b = 5'd5;
            6'b011001:            dec_5b = 5'd6;
            6'b111000, 6'b000111: dec_5b = 5'd7;
            6'b111001, 6'b000110: dec_5b = 5'd8;
            6'b100101:            dec_5b = 5'd9;
            6'b010101:            dec_5b = 5'd10;
            6'b110100:            dec_5b = 5'd11;
            6'b001101:            dec_5b = 5'd12;
            6'b101100:            dec_5b = 5'd13;
            6'b011100:            dec_5b = 5'd14;
            6'b010111, 6'b101000: dec_5b = 5'd15;
            6'b011011, 6'b100100: dec_5b = 5'd16;
            6'b100011:            dec_5b = 5'd17;
            6'b010011:            dec_5b = 5'd18;
            6'b110010:            dec_5b = 5'd19;
            6'b001011:            dec_5b = 5'd20;
            6'b101010:            dec_5b = 5'd21;
            6'b011010:            dec_5b = 5'd22;
            6'b111010, 6'b000101: dec_5b = 5'd23;
            6'b110011, 6'b001100: dec_5b = 5'd24;
            6'b100110:            dec_5b = 5'd25;
            6'b010110:            dec_5b = 5'd26;
            6'b110110, 6'b001001: dec_5b = 5'd27;
            6'b001110:            dec_5b = 5'd28;
            6'b101110, 6'b010001: dec_5b = 5'd29;
            6'b011110, 6'b100001: dec_5b = 5'd30;
            6'b101011, 6'b010100: dec_5b = 5'd31;
            6'b001111, 6'b110000: begin             // K28.x
                dec_5b = 5'd28;
                is_k   = 1'b1;
            end
            default:              ok_6b  = 1'b0;
        endcase
    end

    always_comb begin
        dec_3b = 3'd0;
        ok_4b  = 1'b1;
        case (fghj)
            4'b1011, 4'b0100:                   dec_3b = 3'd0;
            4'b1001:                            dec_3b = 3'd1;
            4'b0101:                            dec_3b = 3'd2;
            4'b1100, 4'b0011:                   dec_3b = 3'd3;
            4'b1101, 4'b0010:                   dec_3b = 3'd4;
            4'b1010:                            dec_3b = 3'd5;
            4'b0110:                            dec_3b = 3'd6;
            4'b1110, 4'b0001, 4'b0111, 4'b1000: dec_3b = 3'd7;  // primary and alternate
            default:                            ok_4b  = 1'b0;  // 0000, 1111
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            byte_valid <= 1'b0;
            code_err   <= 1'b0;
        end else begin
            byte_valid <= sym_valid;
            code_err   <= sym_valid && !(ok_6b && ok_4b);
        end
    end

    // bad symbols still go out, as a zero data byte
    always_ff @(posedge BUS_CLK) begin
        if (sym_valid) begin
            byte_out.data <= (ok_6b && ok_4b) ? {dec_3b, dec_5b} : 8'h00;
            byte_out.k    <= ok_6b && ok_4b && is_k;
        end
    end

endmodule

//--- verilog/rx_bus_pkg.sv
package rx_bus_pkg;

    localparam int ABUSWIDTH = 16;

    typedef struct packed {
        logic [ABUSWIDTH-1:0] add;
        logic [7:0]           data_in;
        logic                 wr;
        logic                 rd;
    } bus_req_t;

    // register map
    localparam logic [ABUSWIDTH-1:0] ADDR_RESET    = 16'd0;  // soft reset, version on read
    localparam logic [ABUSWIDTH-1:0] ADDR_RX_RESET = 16'd1;  // link reset only
    localparam logic [ABUSWIDTH-1:0] ADDR_CTRL     = 16'd2;
    localparam logic [ABUSWIDTH-1:0] ADDR_SIZE_LO  = 16'd3;
    localparam logic [ABUSWIDTH-1:0] ADDR_SIZE_HI  = 16'd4;
    localparam logic [ABUSWIDTH-1:0] ADDR_DEC_ERR  = 16'd5;
    localparam logic [ABUSWIDTH-1:0] ADDR_LOST_ERR = 16'd6;

    localparam logic [7:0] VERSION = 8'd2;

    // bit 1 set, line inverted by default
    localparam logic [7:0] CTRL_RESET_VAL = 8'h02;

endpackage

//--- verilog/rx_core_regs.sv
`timescale 1ns/1ps

module rx_core_regs
    import rx_bus_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        RST,
    input  bus_req_t    bus,
    input  logic        ready,
    input  logic [15:0] size,
    input  logic [7:0]  dec_err_cnt,
    input  logic [7:0]  lost_cnt,
    output logic [7:0]  bus_data_out,
    output logic        link_rst,
    output logic        full_rst,
    output logic        invert
);

    logic       soft_rst_q;     // write to address 0 seen
    logic       rx_rst_q;       // write to address 0 or 1 seen
    logic [7:0] ctrl;

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            soft_rst_q <= 1'b0;
            rx_rst_q   <= 1'b0;
        end else begin
            soft_rst_q <= bus.wr && (bus.add == ADDR_RESET);
            rx_rst_q   <= bus.wr && (bus.add == ADDR_RESET || bus.add == ADDR_RX_RESET);
        end
    end

    // soft reset pulses, also held for the whole bus reset
    assign full_rst = RST || soft_rst_q;
    assign link_rst = RST || rx_rst_q;

    always_ff @(posedge BUS_CLK) begin
        if (full_rst)
            ctrl <= CTRL_RESET_VAL;
        else if (bus.wr && bus.add == ADDR_CTRL)
            ctrl <= bus.data_in;
    end

    assign invert = ctrl[1];

    // registered readback, follows the address only
    always_ff @(posedge BUS_CLK) begin
        case (bus.add)
            ADDR_RESET:    bus_data_out <= VERSION;
            ADDR_CTRL:     bus_data_out <= {ctrl[7:1], ready};  // bit 0 is link status
            ADDR_SIZE_LO:  bus_data_out <= size[7:0];
            ADDR_SIZE_HI:  bus_data_out <= size[15:8];
            ADDR_DEC_ERR:  bus_data_out <= dec_err_cnt;
            ADDR_LOST_ERR: bus_data_out <= lost_cnt;
            default:       bus_data_out <= 8'h00;
        endcase
    end

endmodule

//--- verilog/rx_frame_assembler.sv
`timescale 1ns/1ps

module rx_frame_assembler
    import rx_link_pkg::*;
(
    input  logic       BUS_CLK,
    input  logic       RST,
    input  logic       link_rst,
    input  dec_byte_t  byte_in,
    input  logic       byte_valid,
    input  logic       code_err,
    output fe_record_t rec,
    output logic       rec_valid
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FRAME,
        S_DROP      // frame broken, wait for EOF or a new SOF
    } state_t;

    state_t     state;
    logic [1:0] idx;

    always_ff @(posedge BUS_CLK) begin
        if (RST || link_rst) begin
            state     <= S_IDLE;
            idx       <= 2'd0;
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= 1'b0;
            if (byte_valid) begin
                if (code_err) begin
                    state <= (state == S_IDLE) ? S_IDLE : S_DROP;
                end else if (byte_in.k) begin
                    idx <= 2'd0;                            // partial record discarded
                    if (byte_in.data == K28_7)
                        state <= S_FRAME;
                    else if (byte_in.data == K28_3)
                        state <= S_IDLE;
                    else if (state == S_FRAME)
                        state <= S_DROP;                    // stray K inside a frame
                end else if (state == S_FRAME) begin
                    if (idx == 2'd2) begin
                        idx       <= 2'd0;
                        rec_valid <= 1'b1;
                    end else begin
                        idx <= idx + 2'd1;
                    end
                end
            end
        end
    end

    // record bytes, first byte in the top byte
    always_ff @(posedge BUS_CLK) begin
        if (byte_valid && !byte_in.k && state == S_FRAME)
            rec[2'd2 - idx] <= byte_in.data;
    end

    a_rec_after_byte: assert property (
        @(posedge BUS_CLK) disable iff (RST) rec_valid |-> $past(byte_valid)
    ) else $error("record pushed without a byte");

endmodule

//--- verilog/rx_link_pkg.sv
package rx_link_pkg;

    // raw line symbol, bit 9 is the first bit on the wire (abcdei fghj)
    typedef logic [9:0] sym10_t;

    typedef struct packed {
        logic [7:0] data;
        logic       k;      // control character
    } dec_byte_t;

    // byte 2 is the first byte of the record
    typedef logic [2:0][7:0] fe_record_t;

    typedef struct packed {
        logic [7:0] header;     // data identifier
        fe_record_t rec;
    } fifo_word_t;

    // K characters as decoded bytes
    localparam logic [7:0] K28_5 = 8'hBC;  // comma, idle
    localparam logic [7:0] K28_7 = 8'hFC;  // start of frame
    localparam logic [7:0] K28_3 = 8'h7C;  // end of frame

    // seven leading bits of K28.1/5/7, both disparities
    localparam logic [6:0] COMMA_P = 7'b0011111;
    localparam logic [6:0] COMMA_N = ~COMMA_P;

    // in-phase commas needed before the link is ready
    localparam int SYNC_COMMAS = 4;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

endpackage

//--- verilog/rx_symbol_align.sv
`timescale 1ns/1ps

module rx_symbol_align
    import rx_link_pkg::*;
(
    input  logic   BUS_CLK,
    input  logic   RST,
    input  logic   link_rst,
    input  logic   rx_data,
    input  logic   invert,
    output sym10_t sym,
    output logic   sym_valid,
    output logic   ready
);

    localparam int CNT_W = $clog2(SYNC_COMMAS + 1);

    sym10_t             sreg;
    sym10_t             shift_nxt;
    logic [3:0]         phase;      // 0 when sreg holds a whole symbol
    logic [CNT_W-1:0]   comma_cnt;
    logic               comma;
    logic               in_phase;

    // next shift value, oldest bit ends up in bit 9
    assign shift_nxt = {sreg[8:0], rx_data ^ invert};
    assign comma     = (shift_nxt[9:3] == COMMA_P) || (shift_nxt[9:3] == COMMA_N);
    assign in_phase  = (phase == 4'd9);

    always_ff @(posedge BUS_CLK) begin
        if (RST || link_rst) begin
            sreg      <= '0;
            phase     <= '0;
            comma_cnt <= '0;
            ready     <= 1'b0;
            sym_valid <= 1'b0;
        end else begin
            sreg      <= shift_nxt;
            sym_valid <= 1'b0;
            if (comma && !(in_phase && comma_cnt != '0)) begin
                // comma at a new phase, start over from here
                phase     <= '0;
                comma_cnt <= CNT_W'(1);
                ready     <= 1'b0;
            end else begin
                phase <= in_phase ? 4'd0 : phase + 4'd1;
                if (comma && comma_cnt < CNT_W'(SYNC_COMMAS))
                    comma_cnt <= comma_cnt + CNT_W'(1);
                if (comma && comma_cnt == CNT_W'(SYNC_COMMAS - 1))
                    ready <= 1'b1;
                sym_valid <= ready && in_phase;  // the comma raising ready is not sent
            end
        end
    end

    assign sym = sreg;

    // a misaligned comma drops ready in the same edge that would emit
    a_valid_needs_ready: assert property (
        @(posedge BUS_CLK) disable iff (RST) sym_valid |-> ready
    ) else $error("symbol emitted while not aligned");

endmodule

//--- verilog/rx_word_fifo.sv
`timescale 1ns/1ps

module rx_word_fifo
    import rx_link_pkg::*;
(
    input  logic        BUS_CLK,
    input  logic        RST,
    input  logic        link_rst,
    input  fe_record_t  wr_rec,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic [7:0]  header,
    output fifo_word_t  data,
    output logic        empty,
    output logic        full,
    output logic [15:0] size,
    output logic [7:0]  lost_cnt
);

    fe_record_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_wr;
    logic               do_rd;

    assign empty = (count == '0);
    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge BUS_CLK) begin
        if (RST || link_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            lost_cnt <= 8'd0;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (FIFO_AW+1)'(do_wr) - (FIFO_AW+1)'(do_rd);
            if (wr_en && full && lost_cnt != 8'hFF)  // saturates
                lost_cnt <= lost_cnt + 8'd1;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (do_wr)
            mem[wr_ptr] <= wr_rec;
    end

    // head word shows without a read request
    assign data = '{header: header, rec: mem[rd_ptr]};
    assign size = 16'(count);

    a_no_read_empty: assert property (
        @(posedge BUS_CLK) disable iff (RST) rd_en |-> !empty
    ) else $error("read from empty FIFO");

    a_size_bound: assert property (
        @(posedge BUS_CLK) disable iff (RST) size <= 16'(FIFO_DEPTH)
    ) else $error("FIFO fill level above depth");

endmodule
